// File: src/isa_pkg.sv
package isa_pkg;

    // Architectural widths
    localparam int ADDR_WIDTH  = 32;
    localparam int INSTR_WIDTH = 32;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // First fetch address after reset
    localparam addr_t RESET_PC = 32'h1c00_0000;

endpackage

// File: src/fetch_pkg.sv
package fetch_pkg;

    // Fetch geometry
    localparam int FETCH_WIDTH = 4;
    localparam int LINE_WIDTH  = 128;
    localparam int LINE_BYTES  = 16;
    localparam int FTQ_DEPTH   = 4;
    localparam int BLOCK_BYTES = FETCH_WIDTH * 4;

    typedef logic [LINE_WIDTH-1:0] cache_line_t;

    // One block of sequential fetch work
    typedef struct packed {
        logic           valid;
        isa_pkg::addr_t start_pc;
        logic           cross_line;
    } fetch_block_t;

    // One slot towards the instruction buffer
    typedef struct packed {
        logic            valid;
        isa_pkg::addr_t  pc;
        isa_pkg::instr_t instr;
    } fetch_instr_t;

    typedef fetch_instr_t [FETCH_WIDTH-1:0] fetch_bundle_t;

endpackage

// File: src/fetch_pc_gen.sv
`timescale 1ns/1ns

module fetch_pc_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  isa_pkg::addr_t         redirect_pc_i,
    input  logic                   queue_full_i,
    output fetch_pkg::fetch_block_t block_o
);

    import isa_pkg::*;
    import fetch_pkg::*;

    addr_t pc;
    addr_t next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // Sequential predictor only
    always_comb begin
        if (flush_i) begin
            next_pc = redirect_pc_i;
        end else if (queue_full_i) begin
            next_pc = pc;
        end else begin
            next_pc = pc + addr_t'(BLOCK_BYTES);
        end
    end

    // Block goes straight into the queue when it has room
    always_comb begin
        block_o.valid      = !queue_full_i && !flush_i;
        block_o.start_pc   = pc;
        block_o.cross_line = (pc[3:2] != 2'b00);
    end

endmodule

// File: src/fetch_target_queue.sv
`timescale 1ns/1ns

module fetch_target_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush_i,
    input  fetch_pkg::fetch_block_t enq_i,
    output logic                    full_o,
    output fetch_pkg::fetch_block_t head_o,
    input  logic                    deq_i
);

    import fetch_pkg::*;

    fetch_block_t entries [FTQ_DEPTH];

    logic [$clog2(FTQ_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FTQ_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FTQ_DEPTH):0]   count;

    logic empty;
    logic do_enq;
    logic do_deq;

    assign empty  = (count == '0);
    assign full_o = (count == ($clog2(FTQ_DEPTH)+1)'(FTQ_DEPTH));

    assign do_enq = enq_i.valid && !full_o;
    assign do_deq = deq_i && !empty;

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < FTQ_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (do_enq && !flush_i) begin
            entries[wr_ptr] <= enq_i;
        end
    end

    // Head is only offered while something is stored
    always_comb begin
        head_o       = entries[rd_ptr];
        head_o.valid = !empty;
    end

endmodule

// File: src/instr_fetch_unit.sv
`timescale 1ns/1ns

module instr_fetch_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  fetch_pkg::fetch_block_t       block_i,
    output logic                          accept_o,
    output logic [1:0]                    icache_req_o,
    output isa_pkg::addr_t [1:0]          icache_addr_o,
    input  logic [1:0]                    icache_valid_i,
    input  fetch_pkg::cache_line_t [1:0]  icache_data_i,
    input  logic                          stall_i,
    output fetch_pkg::fetch_bundle_t      bundle_o
);

    import isa_pkg::*;
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_out
    } state_e;

    state_e state;
    state_e state_nxt;

    addr_t       start_pc_q;
    addr_t       line_addr;
    logic [1:0]  need;
    logic [1:0]  got;
    logic [1:0]  hit;
    logic        drop;
    logic        lines_done;
    cache_line_t line_q [2];

    logic [2*LINE_WIDTH-1:0] lines_cat;
    logic [2:0]              word_idx;

    // Take a new block when idle or when the current bundle leaves
    assign accept_o = block_i.valid && !flush_i &&
                      (state == st_idle || (state == st_out && !stall_i));

    assign icache_req_o = (state == st_wait) ? (need & ~got) : 2'b00;
    assign hit          = icache_valid_i & icache_req_o;
    assign lines_done   = ((got | hit) == need);

    assign line_addr        = start_pc_q & ~addr_t'(LINE_BYTES - 1);
    assign icache_addr_o[0] = line_addr;
    assign icache_addr_o[1] = line_addr + addr_t'(LINE_BYTES);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept_o) state_nxt = st_wait;
            end
            st_wait: begin
                // Dropped blocks still wait out their responses
                if (lines_done) state_nxt = (drop || flush_i) ? st_idle : st_out;
            end
            st_out: begin
                if (flush_i) state_nxt = st_idle;
                else if (!stall_i) state_nxt = accept_o ? st_wait : st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            start_pc_q <= RESET_PC;
            need       <= 2'b00;
            got        <= 2'b00;
            drop       <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept_o) begin
                start_pc_q <= block_i.start_pc;
                need       <= {block_i.cross_line, 1'b1};
                got        <= 2'b00;
                drop       <= 1'b0;
            end else if (state == st_wait) begin
                got <= got | hit;
                if (flush_i) drop <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (hit[p]) line_q[p] <= icache_data_i[p];
        end
    end

    // Four words from the start offset across both lines
    always_comb begin
        lines_cat = {line_q[1], line_q[0]};
        word_idx  = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            word_idx          = {1'b0, start_pc_q[3:2]} + 3'(k);
            bundle_o[k].valid = (state == st_out) && !flush_i;
            bundle_o[k].pc    = start_pc_q + addr_t'(4 * k);
            bundle_o[k].instr = lines_cat[word_idx*INSTR_WIDTH +: INSTR_WIDTH];
        end
    end

endmodule

// File: src/frontend.sv
`timescale 1ns/1ns

module frontend (
    input  logic                         clk,
    input  logic                         rst_n,

    // Dual port instruction cache
    output logic [1:0]                   icache_req_o,
    output isa_pkg::addr_t [1:0]         icache_addr_o,
    input  logic [1:0]                   icache_valid_i,
    input  fetch_pkg::cache_line_t [1:0] icache_data_i,

    // Backend redirect
    input  logic                         backend_flush_i,
    input  isa_pkg::addr_t               backend_next_pc_i,

    // Instruction buffer
    input  logic                         instr_buffer_stall_i,
    output fetch_pkg::fetch_bundle_t     instr_buffer_o
);

    import fetch_pkg::*;

    fetch_block_t pc_gen_block;
    fetch_block_t ftq_head;
    logic         ftq_full;
    logic         ifu_accept;

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (backend_flush_i),
        .redirect_pc_i(backend_next_pc_i),
        .queue_full_i (ftq_full),
        .block_o      (pc_gen_block)
    );

    fetch_target_queue u_ftq (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush_i(backend_flush_i),
        .enq_i  (pc_gen_block),
        .full_o (ftq_full),
        .head_o (ftq_head),
        .deq_i  (ifu_accept)
    );

    instr_fetch_unit u_ifu (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (backend_flush_i),
        .block_i       (ftq_head),
        .accept_o      (ifu_accept),
        .icache_req_o  (icache_req_o),
        .icache_addr_o (icache_addr_o),
        .icache_valid_i(icache_valid_i),
        .icache_data_i (icache_data_i),
        .stall_i       (instr_buffer_stall_i),
        .bundle_o      (instr_buffer_o)
    );

endmodule

// File: verif/frontend_properties.sv
`timescale 1ns/1ns

module frontend_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     flush_i,
    input fetch_pkg::fetch_block_t  block_i,
    input logic                     accept_i,
    input logic [1:0]               icache_req_i,
    input logic [1:0]               icache_valid_i,
    input logic                     stall_i,
    input fetch_pkg::fetch_bundle_t bundle_i
);

    import fetch_pkg::*;

    // One or two line requests in the cycle after accept
    accept_issues_request: assert property (@(posedge clk) disable iff (!rst_n)
        accept_i |=> (icache_req_i == {$past(block_i.cross_line), 1'b1}))
        else $error("line requests not issued after accept");

    req0_held: assert property (@(posedge clk) disable iff (!rst_n)
        (icache_req_i[0] && !icache_valid_i[0]) |=> icache_req_i[0])
        else $error("port 0 request dropped before its response");

    req1_held: assert property (@(posedge clk) disable iff (!rst_n)
        (icache_req_i[1] && !icache_valid_i[1]) |=> icache_req_i[1])
        else $error("port 1 request dropped before its response");

    // Flush may cancel a stalled bundle
    bundle_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (bundle_i[0].valid && stall_i) |=> (flush_i || $stable(bundle_i)))
        else $error("bundle changed while stalled");

endmodule

bind instr_fetch_unit frontend_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .block_i       (block_i),
    .accept_i      (accept_o),
    .icache_req_i  (icache_req_o),
    .icache_valid_i(icache_valid_i),
    .stall_i       (stall_i),
    .bundle_i      (bundle_o)
);

// File: verif/tb_frontend.sv
`timescale 1ns/1ns

module tb_frontend;

    import isa_pkg::*;
    import fetch_pkg::*;

    // About 300 bundles at up to 13 cycles each, including stalls
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                   clk;
    logic                   rst_n;
    logic [1:0]             icache_req;
    addr_t [1:0]            icache_addr;
    logic [1:0]             icache_valid;
    cache_line_t [1:0]      icache_data;
    logic                   flush;
    addr_t                  next_pc;
    logic                   stall;
    fetch_bundle_t          bundle;

    addr_t                  exp_pc;
    fetch_bundle_t          held;
    logic                   held_valid;
    logic [1:0]             pend;
    int unsigned            lat [2];
    addr_t                  req_addr [2];
    int unsigned            cycles = 0;
    int unsigned            checks = 0;
    int unsigned            errors = 0;
    int unsigned            bundles = 0;
    int unsigned            flushes = 0;

    frontend DUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .icache_req_o        (icache_req),
        .icache_addr_o       (icache_addr),
        .icache_valid_i      (icache_valid),
        .icache_data_i       (icache_data),
        .backend_flush_i     (flush),
        .backend_next_pc_i   (next_pc),
        .instr_buffer_stall_i(stall),
        .instr_buffer_o      (bundle)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reference memory contents
    function automatic instr_t mem_word(input addr_t a);
        logic [31:0] x;
        int unsigned sh;
        x  = a ^ 32'h5a5a_0000;
        sh = a[6:2];
        return (x << sh) | (x >> (32 - sh));
    endfunction

    function automatic cache_line_t line_data(input addr_t a);
        cache_line_t line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = mem_word(a + addr_t'(4 * w));
        end
        return line;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR @%0t: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Cache model answers each port after 1 to 4 cycles
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < 2; p++) begin
            icache_valid[p] = 1'b0;
            if (pend[p]) begin
                lat[p] = lat[p] - 1;
                if (lat[p] == 0) begin
                    icache_valid[p] = 1'b1;
                    icache_data[p]  = line_data(req_addr[p]);
                    pend[p]         = 1'b0;
                end
            end else if (rst_n && icache_req[p]) begin
                pend[p]     = 1'b1;
                lat[p]      = 1 + $urandom % 4;
                req_addr[p] = icache_addr[p];
            end
        end
    end

    // Compare every consumed bundle against the reference stream
    always @(negedge clk) begin
        if (rst_n) begin
            if (held_valid && bundle[0].valid) begin
                check_value("bundle held while stalled", bundle === held, 1);
            end
            if (bundle[0].valid && !stall) begin
                for (int k = 0; k < FETCH_WIDTH; k++) begin
                    check_value($sformatf("slot %0d valid", k), bundle[k].valid, 1);
                    check_value($sformatf("slot %0d pc", k), bundle[k].pc,
                                exp_pc + addr_t'(4 * k));
                    check_value($sformatf("slot %0d instr", k), bundle[k].instr,
                                mem_word(exp_pc + addr_t'(4 * k)));
                end
                exp_pc = exp_pc + addr_t'(BLOCK_BYTES);
                bundles++;
            end
            held_valid = bundle[0].valid && stall;
            held       = bundle;
            if (flush) begin
                exp_pc     = next_pc;
                held_valid = 1'b0;
                flushes++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    task automatic wait_bundles(input int unsigned n);
        int unsigned target;
        target = bundles + n;
        while (bundles < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic pulse_flush(input addr_t pc);
        flush   = 1'b1;
        next_pc = pc;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    task automatic wait_request();
        do begin
            @(posedge clk);
            #1;
        end while (icache_req == 2'b00);
    endtask

    task automatic random_mix(input int unsigned count);
        int unsigned target;
        int unsigned r;
        target = bundles + count;
        while (bundles < target) begin
            @(posedge clk);
            #1;
            r     = $urandom % 100;
            flush = (r < 2);
            if (r < 2) next_pc = $urandom & 32'hffff_fffc;
            stall = (($urandom % 100) < 25);
        end
        flush = 1'b0;
        stall = 1'b0;
    endtask

    initial begin
        int unsigned n;
        void'($urandom(32'h95ca));
        rst_n        = 1'b0;
        flush        = 1'b0;
        next_pc      = '0;
        stall        = 1'b0;
        icache_valid = '0;
        icache_data  = '0;
        pend         = '0;
        held_valid   = 1'b0;
        exp_pc       = RESET_PC;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Sequential stream from the reset address
        wait_bundles(40);

        // Unaligned redirects cross a line boundary
        for (int i = 1; i < 4; i++) begin
            pulse_flush(32'h2400_0000 + addr_t'(i * 32'h100) + addr_t'(4 * i));
            wait_bundles(5);
        end

        // Stall long enough to fill the queue
        for (int i = 0; i < 12; i++) begin
            stall = 1'b1;
            n     = 1 + $urandom % 20;
            repeat (n) begin
                @(posedge clk);
                #1;
            end
            stall = 1'b0;
            wait_bundles(2);
        end

        // Redirect while lines are still outstanding
        for (int i = 0; i < 6; i++) begin
            wait_request();
            pulse_flush(32'h3000_0000 + addr_t'(i * 32'h40) + addr_t'(4 * (i % 4)));
            wait_bundles(3);
        end

        random_mix(200);

        $display("Checks: %0d, errors: %0d, bundles: %0d, flushes: %0d",
                 checks, errors, bundles, flushes);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: flist.f
src/isa_pkg.sv
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_target_queue.sv
src/instr_fetch_unit.sv
src/frontend.sv
verif/frontend_properties.sv
verif/tb_frontend.sv

// File: run.sh
#!/bin/sh
# Compile and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module tb_frontend -Mdir obj_dir -o sim_frontend -f flist.f
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/sim_frontend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
